/* Makefile */
TOP = rename_unit_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -j 0 -f project.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "^Everything OK$$"

clean:
	rm -rf obj_dir

/* project.f */
source/lc3b_types.sv
source/two_write_regfile.sv
source/regfile_data.sv
source/regfile.sv
source/rob_tag_alloc.sv
source/rename_unit.sv
sim/clock_gen.sv
sim/rename_unit_tb.sv

/* sim/clock_gen.sv */
`timescale 1ns/100ps

module clock_gen #(
    parameter int half_period  = 2,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic reset
);

    // free-running clock, first rising edge at half_period
    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // reset covers the first reset_cycles rising edges
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule : clock_gen

/* sim/rename_unit_tb.sv */
`timescale 1ns/100ps

module rename_unit_tb;
    import lc3b_types::*;

    localparam int num_regs        = 8;
    localparam int depth           = 2 ** lc3b_tag_width;
    localparam int reset_cycles    = 5;
    // directed sequence plus two idle cycles at the end
    localparam int directed_cycles = 42;
    localparam int random_cycles   = 400;
    localparam int timeout_limit   = reset_cycles + directed_cycles + random_cycles + 50;

    logic     clk;
    logic     reset;
    logic     flush;
    logic     issue_valid;
    logic     writes_dest;
    logic     commit_valid;
    lc3b_reg  dest;
    lc3b_reg  sr1;
    lc3b_reg  sr2;
    lc3b_reg  commit_dest;
    lc3b_word commit_value;
    logic     issue_ready;
    rob_tag   issue_tag;
    logic     sr1_busy;
    logic     sr2_busy;
    rob_tag   sr1_tag;
    rob_tag   sr2_tag;
    lc3b_word sr1_data;
    lc3b_word sr2_data;

    // reference state advanced once per rising edge
    logic     m_busy [num_regs];
    rob_tag   m_tag [num_regs];
    lc3b_word m_value [num_regs];
    // destination of each tag in flight steers random commits
    lc3b_reg  m_dest_of [depth];
    rob_tag   m_head;
    rob_tag   m_tail;
    int       m_count;

    int          errors;
    int          checks;
    int          cycles;
    logic [31:0] rnd_state;

    clock_gen #(
        .half_period (2),
        .reset_cycles(reset_cycles)
    ) clock0 (
        .clk  (clk),
        .reset(reset)
    );

    rename_unit #(
        .data_width(lc3b_data_width),
        .tag_width (lc3b_tag_width)
    ) dut0 (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .issue_valid  (issue_valid),
        .writes_dest  (writes_dest),
        .dest         (dest),
        .sr1          (sr1),
        .sr2          (sr2),
        .commit_dest  (commit_dest),
        .commit_valid (commit_valid),
        .commit_value (commit_value),
        .issue_ready  (issue_ready),
        .issue_tag    (issue_tag),
        .sr1_busy     (sr1_busy),
        .sr2_busy     (sr2_busy),
        .sr1_tag      (sr1_tag),
        .sr2_tag      (sr2_tag),
        .sr1_data     (sr1_data),
        .sr2_data     (sr2_data)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // one clock edge of the register status rules
    function automatic void model_step();
        logic take_issue;
        logic take_commit;
        // a flush cycle accepts neither side
        take_issue  = issue_valid && (m_count < depth) && !flush;
        take_commit = commit_valid && (m_count > 0) && !flush;
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                m_busy[i]  = 1'b0;
                m_tag[i]   = '0;
                m_value[i] = '0;
            end
            m_head  = '0;
            m_tail  = '0;
            m_count = 0;
        end else if (flush) begin
            // values and tags survive a flush
            for (int i = 0; i < num_regs; i++) begin
                m_busy[i] = 1'b0;
            end
            m_head  = '0;
            m_tail  = '0;
            m_count = 0;
        end else begin
            // commit before issue so that a same-cycle issue leaves the register busy
            if (take_commit) begin
                m_value[commit_dest] = commit_value;
                // only the writer the register still waits on frees it
                if (m_tag[commit_dest] == m_head) begin
                    m_busy[commit_dest] = 1'b0;
                end
                m_head  = rob_tag'(m_head + 1);
                m_count = m_count - 1;
            end
            if (take_issue) begin
                if (writes_dest) begin
                    m_busy[dest] = 1'b1;
                    m_tag[dest]  = m_tail;
                end
                m_dest_of[m_tail] = dest;
                m_tail  = rob_tag'(m_tail + 1);
                m_count = m_count + 1;
            end
        end
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_tag(input string name, input rob_tag got, input rob_tag exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input lc3b_word got, input lc3b_word exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // inputs for one cycle applied at the next rising edge
    task automatic drive(input logic iv, input logic wd, input lc3b_reg d, input logic cv,
                         input lc3b_reg cd, input lc3b_word val, input logic fl,
                         input lc3b_reg s1, input lc3b_reg s2);
        @(posedge clk);
        issue_valid  <= iv;
        writes_dest  <= wd;
        dest         <= d;
        commit_valid <= cv;
        commit_dest  <= cd;
        commit_value <= val;
        flush        <= fl;
        sr1          <= s1;
        sr2          <= s2;
    endtask

    // idle cycles that read every register once
    task automatic sweep_reads();
        for (int r = 0; r < num_regs; r++) begin
            drive(1'b0, 1'b0, 3'd0, 1'b0, 3'd0, 16'h0, 1'b0, lc3b_reg'(r),
                  lc3b_reg'(num_regs - 1 - r));
        end
    endtask

    task automatic random_mix();
        logic [31:0] a;
        logic [31:0] b;
        lc3b_reg     cd;
        for (int i = 0; i < random_cycles; i++) begin
            // model state is settled at the falling edge
            @(negedge clk);
            rnd_state = lcg_next(rnd_state);
            a         = rnd_state;
            rnd_state = lcg_next(rnd_state);
            b         = rnd_state;
            // mostly commit to the register the head tag wrote
            if (a[23]) begin
                cd = m_dest_of[m_head];
            end else begin
                cd = a[22:20];
            end
            drive(a[31:30] != 2'b00, a[29:28] != 2'b00, a[27:25], a[24], cd, b[25:10],
                  a[19:14] == 6'd0, b[31:29], b[28:26]);
        end
    endtask

    // outputs against the model half a cycle after each step
    always @(negedge clk) begin
        check_bit("issue_ready", issue_ready, m_count != depth);
        check_tag("issue_tag", issue_tag, m_tail);
        check_bit("sr1_busy", sr1_busy, m_busy[sr1]);
        check_bit("sr2_busy", sr2_busy, m_busy[sr2]);
        check_tag("sr1_tag", sr1_tag, m_tag[sr1]);
        check_tag("sr2_tag", sr2_tag, m_tag[sr2]);
        check_word("sr1_data", sr1_data, m_value[sr1]);
        check_word("sr2_data", sr2_data, m_value[sr2]);
    end

    always @(posedge clk) begin
        model_step();
    end

    initial begin
        cycles = 0;
        while (cycles < timeout_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not end within %0d cycles", timeout_limit);
        $display("Something failed");
        $finish;
    end

    initial begin
        errors       = 0;
        checks       = 0;
        rnd_state    = 32'h6407;
        flush        = 1'b0;
        issue_valid  = 1'b0;
        writes_dest  = 1'b0;
        commit_valid = 1'b0;
        dest         = '0;
        sr1          = '0;
        sr2          = '0;
        commit_dest  = '0;
        commit_value = '0;
        for (int i = 0; i < num_regs; i++) begin
            m_busy[i]  = 1'b0;
            m_tag[i]   = '0;
            m_value[i] = '0;
        end
        for (int i = 0; i < depth; i++) begin
            m_dest_of[i] = '0;
        end
        m_head  = '0;
        m_tail  = '0;
        m_count = 0;
        wait (reset == 1'b0);

        // all registers idle and zero after reset
        sweep_reads();

        // issue r3 with tag 0 and then its matching commit
        drive(1'b1, 1'b1, 3'd3, 1'b0, 3'd0, 16'h0, 1'b0, 3'd3, 3'd3);
        drive(1'b0, 1'b0, 3'd0, 1'b1, 3'd3, 16'h1234, 1'b0, 3'd3, 3'd4);
        drive(1'b0, 1'b0, 3'd0, 1'b0, 3'd0, 16'h0, 1'b0, 3'd3, 3'd3);

        // r5 is reissued so the commit of tag 1 is stale and tag 2 frees it
        drive(1'b1, 1'b1, 3'd5, 1'b0, 3'd0, 16'h0, 1'b0, 3'd5, 3'd3);
        drive(1'b1, 1'b1, 3'd5, 1'b0, 3'd0, 16'h0, 1'b0, 3'd5, 3'd5);
        drive(1'b0, 1'b0, 3'd0, 1'b1, 3'd5, 16'haaaa, 1'b0, 3'd5, 3'd5);
        drive(1'b0, 1'b0, 3'd0, 1'b1, 3'd5, 16'h5555, 1'b0, 3'd5, 3'd6);
        // r6 issue and commit in one cycle stays busy
        drive(1'b1, 1'b1, 3'd6, 1'b0, 3'd0, 16'h0, 1'b0, 3'd6, 3'd5);
        drive(1'b1, 1'b1, 3'd6, 1'b1, 3'd6, 16'h0606, 1'b0, 3'd6, 3'd6);
        drive(1'b0, 1'b0, 3'd0, 1'b1, 3'd6, 16'h6666, 1'b0, 3'd6, 3'd6);
        drive(1'b0, 1'b0, 3'd0, 1'b0, 3'd0, 16'h0, 1'b0, 3'd6, 3'd5);

        // eight issues fill every tag and the ninth is held off
        for (int r = 0; r < num_regs; r++) begin
            drive(1'b1, 1'b1, lc3b_reg'(r), 1'b0, 3'd0, 16'h0, 1'b0, lc3b_reg'(r), 3'd3);
        end
        drive(1'b1, 1'b1, 3'd1, 1'b0, 3'd0, 16'h0, 1'b0, 3'd1, 3'd0);
        drive(1'b0, 1'b0, 3'd0, 1'b0, 3'd0, 16'h0, 1'b0, 3'd1, 3'd7);

        // flush frees everything while committed data stays
        drive(1'b0, 1'b0, 3'd0, 1'b0, 3'd0, 16'h0, 1'b1, 3'd3, 3'd5);
        sweep_reads();
        // nothing is in flight so this commit must not write r2
        drive(1'b0, 1'b0, 3'd0, 1'b1, 3'd2, 16'hdead, 1'b0, 3'd2, 3'd2);
        drive(1'b0, 1'b0, 3'd0, 1'b0, 3'd0, 16'h0, 1'b0, 3'd2, 3'd3);

        random_mix();

        drive(1'b0, 1'b0, 3'd0, 1'b0, 3'd0, 16'h0, 1'b0, 3'd0, 3'd1);
        drive(1'b0, 1'b0, 3'd0, 1'b0, 3'd0, 16'h0, 1'b0, 3'd2, 3'd3);
        // let the last comparison run first
        @(negedge clk);
        #1;
        $display("errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule : rename_unit_tb

/* source/lc3b_types.sv */
package lc3b_types;

    // default datapath width of the LC-3b
    localparam int lc3b_data_width = 16;

    // default tag width, eight reorder-buffer entries
    localparam int lc3b_tag_width = 3;

    // register number r0 to r7
    typedef logic [2:0] lc3b_reg;

    // one 16-bit register value
    typedef logic [lc3b_data_width-1:0] lc3b_word;

    // reorder-buffer tag of a pending writer
    typedef logic [lc3b_tag_width-1:0] rob_tag;

endpackage : lc3b_types

/* source/regfile.sv */
`timescale 1ns/100ps

module regfile #(
    parameter int data_width = lc3b_types::lc3b_data_width,
    parameter int tag_width  = lc3b_types::lc3b_tag_width
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    // accept pulses from the tag allocator
    input  logic                  do_issue,
    input  logic                  writes_dest,
    input  logic                  do_commit,
    // tag handed to the issuing instruction
    input  lc3b_types::rob_tag    issue_tag,
    // tag of the oldest entry, the one committing
    input  lc3b_types::rob_tag    commit_tag,
    input  lc3b_types::lc3b_word  commit_value,
    input  lc3b_types::lc3b_reg   sr1,
    input  lc3b_types::lc3b_reg   sr2,
    input  lc3b_types::lc3b_reg   dest,
    input  lc3b_types::lc3b_reg   commit_dest,
    // source status for the reservation stations
    output logic                  sr1_busy,
    output logic                  sr2_busy,
    output lc3b_types::rob_tag    sr1_tag,
    output lc3b_types::rob_tag    sr2_tag,
    output lc3b_types::lc3b_word  sr1_data,
    output lc3b_types::lc3b_word  sr2_data
);
    import lc3b_types::*;

    // issue only claims a register when the instruction has a destination
    logic   issue_load;
    // state of the committing register
    logic   commit_busy;
    rob_tag commit_entry;
    // commit still owns the register
    logic   commit_clear;

    assign issue_load = do_issue & writes_dest;

    // a later issue to the same register has replaced the tag
    // so an older commit must leave busy alone
    assign commit_clear = do_commit & commit_busy & (commit_entry == commit_tag);

    // busy bits, issue on port a sets, commit on port b clears
    // port a priority keeps busy set on a same-cycle issue and commit
    two_write_regfile #(
        .data_width(1)
    ) busy_reg (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .load_a   (issue_load),
        .load_b   (commit_clear),
        .in_a     (1'b1),
        .in_b     (1'b0),
        .sr1      (sr1),
        .sr2      (sr2),
        .dest_a   (dest),
        .dest_b   (commit_dest),
        .reg_a    (sr1_busy),
        .reg_b    (sr2_busy),
        .dest_out (commit_busy)
    );

    // committed values, written on every accepted commit
    // the dest read port is not needed here
    regfile_data #(
        .data_width(data_width)
    ) value_reg (
        .clk      (clk),
        .reset    (reset),
        .load     (do_commit),
        .in       (commit_value),
        .waddr    (commit_dest),
        .sr1      (sr1),
        .sr2      (sr2),
        .dest     (commit_dest),
        .reg_a    (sr1_data),
        .reg_b    (sr2_data),
        .dest_out ()
    );

    // tag of the pending writer, written at issue and looked up at commit
    regfile_data #(
        .data_width(tag_width)
    ) rob_entry_reg (
        .clk      (clk),
        .reset    (reset),
        .load     (issue_load),
        .in       (issue_tag),
        .waddr    (dest),
        .sr1      (sr1),
        .sr2      (sr2),
        .dest     (commit_dest),
        .reg_a    (sr1_tag),
        .reg_b    (sr2_tag),
        .dest_out (commit_entry)
    );

endmodule : regfile

/* source/regfile_data.sv */
`timescale 1ns/100ps

module regfile_data #(
    parameter int data_width = lc3b_types::lc3b_data_width
) (
    input  logic                  clk,
    input  logic                  reset,
    // single write port
    input  logic                  load,
    input  logic [data_width-1:0] in,
    input  lc3b_types::lc3b_reg   waddr,
    // three read addresses
    input  lc3b_types::lc3b_reg   sr1,
    input  lc3b_types::lc3b_reg   sr2,
    input  lc3b_types::lc3b_reg   dest,
    output logic [data_width-1:0] reg_a,
    output logic [data_width-1:0] reg_b,
    output logic [data_width-1:0] dest_out
);
    import lc3b_types::*;

    // one entry per architectural register
    localparam int num_regs = 2 ** $bits(lc3b_reg);

    logic [data_width-1:0] data [num_regs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                data[i] <= '0;
            end
        end else if (load) begin
            data[waddr] <= in;
        end
    end

    // reads see the state before this cycle's write
    assign reg_a    = data[sr1];
    assign reg_b    = data[sr2];
    assign dest_out = data[dest];

endmodule : regfile_data

/* source/rename_unit.sv */
`timescale 1ns/100ps

module rename_unit #(
    parameter int data_width = lc3b_types::lc3b_data_width,
    parameter int tag_width  = lc3b_types::lc3b_tag_width
) (
    input  logic                 clk,
    input  logic                 reset,
    // empties the allocator and drops every busy bit
    input  logic                 flush,
    // issue side
    input  logic                 issue_valid,
    input  logic                 writes_dest,
    input  lc3b_types::lc3b_reg  dest,
    input  lc3b_types::lc3b_reg  sr1,
    input  lc3b_types::lc3b_reg  sr2,
    // commit side, tag comes from the allocator head
    input  lc3b_types::lc3b_reg  commit_dest,
    input  logic                 commit_valid,
    input  lc3b_types::lc3b_word commit_value,
    output logic                 issue_ready,
    output lc3b_types::rob_tag   issue_tag,
    // source operand status
    output logic                 sr1_busy,
    output logic                 sr2_busy,
    output lc3b_types::rob_tag   sr1_tag,
    output lc3b_types::rob_tag   sr2_tag,
    output lc3b_types::lc3b_word sr1_data,
    output lc3b_types::lc3b_word sr2_data
);
    import lc3b_types::*;

    logic   do_issue;
    logic   do_commit;
    rob_tag commit_tag;

    // tag allocator, in-order head and tail
    rob_tag_alloc #(
        .tag_width(tag_width)
    ) alloc0 (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .issue_valid  (issue_valid),
        .commit_valid (commit_valid),
        .issue_ready  (issue_ready),
        .do_issue     (do_issue),
        .do_commit    (do_commit),
        .issue_tag    (issue_tag),
        .commit_tag   (commit_tag)
    );

    // busy, tag and value per register
    regfile #(
        .data_width(data_width),
        .tag_width (tag_width)
    ) regs0 (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .do_issue     (do_issue),
        .writes_dest  (writes_dest),
        .do_commit    (do_commit),
        .issue_tag    (issue_tag),
        .commit_tag   (commit_tag),
        .commit_value (commit_value),
        .sr1          (sr1),
        .sr2          (sr2),
        .dest         (dest),
        .commit_dest  (commit_dest),
        .sr1_busy     (sr1_busy),
        .sr2_busy     (sr2_busy),
        .sr1_tag      (sr1_tag),
        .sr2_tag      (sr2_tag),
        .sr1_data     (sr1_data),
        .sr2_data     (sr2_data)
    );

endmodule : rename_unit

/* source/rob_tag_alloc.sv */
`timescale 1ns/100ps

module rob_tag_alloc #(
    parameter int tag_width = lc3b_types::lc3b_tag_width
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    // requests from dispatch and from the head of the reorder buffer
    input  logic               issue_valid,
    input  logic               commit_valid,
    // a free tag exists
    output logic               issue_ready,
    // accept pulses for the register status file
    output logic               do_issue,
    output logic               do_commit,
    // next tag to hand out
    output lc3b_types::rob_tag issue_tag,
    // oldest tag in flight
    output lc3b_types::rob_tag commit_tag
);

    // count is one wider than a tag so all tags in use sets only the top bit
    localparam logic [tag_width:0] full_count = {1'b1, {tag_width{1'b0}}};

    logic [tag_width-1:0] head;
    logic [tag_width-1:0] tail;
    logic [tag_width:0]   count;

    assign issue_ready = (count != full_count);

    // nothing is accepted in a flush cycle
    assign do_issue  = issue_valid & issue_ready & ~flush;
    // commit on an empty allocator is dropped
    assign do_commit = commit_valid & (count != '0) & ~flush;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // pointers wrap on their own at 2**tag_width
            if (do_issue) begin
                tail <= tail + 1'b1;
            end
            if (do_commit) begin
                head <= head + 1'b1;
            end
            // issue and commit together leave the count unchanged
            case ({do_issue, do_commit})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign issue_tag  = tail;
    assign commit_tag = head;

endmodule : rob_tag_alloc

/* source/two_write_regfile.sv */
`timescale 1ns/100ps

module two_write_regfile #(
    parameter int data_width = lc3b_types::lc3b_data_width
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    // write strobes, port a wins on a shared address
    input  logic                  load_a,
    input  logic                  load_b,
    input  logic [data_width-1:0] in_a,
    input  logic [data_width-1:0] in_b,
    // source read addresses
    input  lc3b_types::lc3b_reg   sr1,
    input  lc3b_types::lc3b_reg   sr2,
    // write addresses of the two ports
    input  lc3b_types::lc3b_reg   dest_a,
    input  lc3b_types::lc3b_reg   dest_b,
    output logic [data_width-1:0] reg_a,
    output logic [data_width-1:0] reg_b,
    // entry at dest_b
    output logic [data_width-1:0] dest_out
);
    import lc3b_types::*;

    // one entry per architectural register
    localparam int num_regs = 2 ** $bits(lc3b_reg);

    logic [data_width-1:0] data [num_regs];

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            // both reset and flush empty the whole array
            for (int i = 0; i < num_regs; i++) begin
                data[i] <= '0;
            end
        end else begin
            // port b goes first
            if (load_b) begin
                data[dest_b] <= in_b;
            end
            // the later write to the same entry takes effect, so a wins
            if (load_a) begin
                data[dest_a] <= in_a;
            end
        end
    end

    // combinational reads from the stored state
    // no bypass of a write in the same cycle
    assign reg_a = data[sr1];
    assign reg_b = data[sr2];

    // lets the owner look at the entry port b is about to write
    assign dest_out = data[dest_b];

endmodule : two_write_regfile
